// File: mesi_isc.f
+incdir+include
rtl/mesi_bus_pkg.sv
rtl/mesi_isc_pkg.sv
rtl/mesi_isc_bcast_if.sv
rtl/mesi_isc_breq_arb.sv
rtl/mesi_isc_bcast_fifo.sv
rtl/mesi_isc_snoop_ctrl.sv
rtl/mesi_isc.sv
tb/mesi_isc_tb.sv

// File: Makefile
# Verilator build for the MESI inter-snoop controller testbench
VERILATOR ?= verilator
TOP       ?= mesi_isc_tb
FILELIST  ?= mesi_isc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Regression passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/mesi_isc_tb.sv
`include "mesi_isc_defs.svh"

module mesi_isc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N = `MESI_NUM_MASTERS;
	localparam int DEPTH = `MESI_BCAST_FIFO_DEPTH;
	localparam int TIMEOUT = 2000; // Cycles allowed for a drain
	localparam int PH_IDLE = 0;
	localparam int PH_SNOOP = 1;
	localparam int PH_ENABLE = 2;

	logic clk = 1'b0;
	logic rst;
	mesi_bus_pkg::mbus_cmd_e [N-1:0] mbus_cmd_i;
	mesi_bus_pkg::addr_t [N-1:0] mbus_addr_i;
	logic [N-1:0] mbus_ack_o;
	logic [N-1:0] cbus_ack_i;
	mesi_bus_pkg::addr_t cbus_addr_o;
	mesi_bus_pkg::cbus_cmd_e [N-1:0] cbus_cmd_o;

	logic [31:0] rng;
	bit hold_idle; // Quiet inputs with outputs at their reset values
	bit gen_en; // Masters may start new commands
	bit slow_snoop; // Acks delayed by 40 cycles
	int ack_wait [N]; // -1 when no ack is scheduled
	logic [N-1:0] prev_ack;

	// Reference model of the acknowledged broadcasts in order and the one in service
	bit exp_write [$];
	int exp_src [$];
	mesi_bus_pkg::addr_t exp_addr [$];
	int svc_phase;
	int svc_src;
	bit svc_write;
	mesi_bus_pkg::addr_t svc_addr;
	logic [N-1:0] svc_pend;
	int accepted;
	int served;
	int max_open;
	int errors;
	bit timed_out;

	mesi_isc mesi_isc_inst (
		.clk        (clk),
		.rst        (rst),
		.mbus_cmd_i (mbus_cmd_i),
		.mbus_addr_i(mbus_addr_i),
		.mbus_ack_o (mbus_ack_o),
		.cbus_ack_i (cbus_ack_i),
		.cbus_addr_o(cbus_addr_o),
		.cbus_cmd_o (cbus_cmd_o)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic bit is_bcast(mesi_bus_pkg::mbus_cmd_e c);
		return c == mesi_bus_pkg::MBUS_RD_BCAST || c == mesi_bus_pkg::MBUS_WR_BCAST;
	endfunction

	function automatic mesi_bus_pkg::cbus_cmd_e snoop_of(bit wr);
		return wr ? mesi_bus_pkg::CBUS_WR_SNOOP : mesi_bus_pkg::CBUS_RD_SNOOP;
	endfunction

	function automatic mesi_bus_pkg::cbus_cmd_e enable_of(bit wr);
		return wr ? mesi_bus_pkg::CBUS_EN_WR : mesi_bus_pkg::CBUS_EN_RD;
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("Fail at %0d ns: %s", $time, msg);
	endtask

	// ***********************************************************************
	// Checks on the DUT outputs sampled at the falling edge
	// ***********************************************************************

	task automatic check_reset_values();
		assert (mbus_ack_o == '0) else report_fail("main-bus ack high in reset");
		assert (cbus_addr_o == '0) else report_fail("coherence address not zero in reset");
		for (int i = 0; i < N; i++)
			assert (cbus_cmd_o[i] == mesi_bus_pkg::CBUS_NOP)
				else report_fail($sformatf("master %0d coherence command not nop in reset", i));
	endtask

	task automatic check_main_acks();
		int open_cnt;
		assert ($countones(mbus_ack_o) <= 1) else report_fail("two masters acked in one cycle");
		for (int i = 0; i < N; i++) begin
			if (mbus_ack_o[i]) begin
				assert (is_bcast(mbus_cmd_i[i]))
					else report_fail($sformatf("master %0d acked without a broadcast", i));
				assert (!prev_ack[i]) else report_fail($sformatf("master %0d ack too long", i));
				exp_write.push_back(mbus_cmd_i[i] == mesi_bus_pkg::MBUS_WR_BCAST);
				exp_src.push_back(i);
				exp_addr.push_back(mbus_addr_i[i]);
				accepted++;
			end
		end
		open_cnt = accepted - served;
		if (open_cnt > max_open)
			max_open = open_cnt;
		assert (open_cnt <= DEPTH + 1)
			else report_fail($sformatf("%0d broadcasts open, limit %0d", open_cnt, DEPTH + 1));
	endtask

	task automatic check_coherence();
		mesi_bus_pkg::cbus_cmd_e want;
		bit active;
		// Acks driven half a cycle ago were taken at the edge just passed
		if (svc_phase == PH_SNOOP) begin
			svc_pend = svc_pend & ~cbus_ack_i;
			if (svc_pend == '0)
				svc_phase = PH_ENABLE;
		end else if (svc_phase == PH_ENABLE && cbus_ack_i[svc_src]) begin
			svc_phase = PH_IDLE;
			served++;
		end
		active = 1'b0;
		for (int i = 0; i < N; i++)
			if (cbus_cmd_o[i] != mesi_bus_pkg::CBUS_NOP)
				active = 1'b1;
		if (svc_phase == PH_IDLE && active) begin // New service seen
			assert (exp_src.size() > 0) else report_fail("service started with nothing acked");
			if (exp_src.size() > 0) begin
				svc_write = exp_write.pop_front();
				svc_src = exp_src.pop_front();
				svc_addr = exp_addr.pop_front();
				for (int j = 0; j < N; j++)
					svc_pend[j] = (j != svc_src);
				svc_phase = PH_SNOOP;
			end
		end
		for (int i = 0; i < N; i++) begin
			want = mesi_bus_pkg::CBUS_NOP;
			if (svc_phase == PH_SNOOP && svc_pend[i])
				want = snoop_of(svc_write);
			else if (svc_phase == PH_ENABLE && i == svc_src)
				want = enable_of(svc_write);
			assert (cbus_cmd_o[i] == want) else report_fail($sformatf(
				"master %0d coherence command %0d, expected %0d", i, cbus_cmd_o[i], want));
		end
		if (svc_phase != PH_IDLE)
			assert (cbus_addr_o == svc_addr) else report_fail($sformatf(
				"coherence address %h, expected %h", cbus_addr_o, svc_addr));
	endtask

	// ***********************************************************************
	// Master and snooper agents
	// ***********************************************************************

	task automatic drive_masters();
		logic [31:0] r;
		for (int i = 0; i < N; i++) begin
			if (mbus_ack_o[i]) begin
				mbus_cmd_i[i] = mesi_bus_pkg::MBUS_NOP; // Broadcast taken
			end else if (!is_bcast(mbus_cmd_i[i])) begin
				r = next_random();
				mbus_cmd_i[i] = mesi_bus_pkg::MBUS_NOP;
				if (gen_en) begin
					case (r[2:0])
						3'd4: mbus_cmd_i[i] = mesi_bus_pkg::MBUS_WRITE;
						3'd5: mbus_cmd_i[i] = mesi_bus_pkg::MBUS_READ;
						3'd6: mbus_cmd_i[i] = mesi_bus_pkg::MBUS_WR_BCAST;
						3'd7: mbus_cmd_i[i] = mesi_bus_pkg::MBUS_RD_BCAST;
						default: mbus_cmd_i[i] = mesi_bus_pkg::MBUS_NOP;
					endcase
				end
				mbus_addr_i[i] = next_random();
			end
		end
	endtask

	task automatic drive_snoopers();
		for (int i = 0; i < N; i++) begin
			cbus_ack_i[i] = 1'b0;
			if (cbus_cmd_o[i] != mesi_bus_pkg::CBUS_NOP && ack_wait[i] < 0)
				ack_wait[i] = slow_snoop ? 40 : int'(next_random() % 7);
			if (ack_wait[i] == 0) begin
				cbus_ack_i[i] = 1'b1; // One-cycle pulse
				ack_wait[i] = -1;
			end else if (ack_wait[i] > 0) begin
				ack_wait[i]--;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst || hold_idle) begin
			check_reset_values();
		end else begin
			check_main_acks();
			check_coherence();
			drive_masters();
			drive_snoopers();
		end
		prev_ack = mbus_ack_o;
	end

	function automatic bit drained();
		bit held;
		held = 1'b0;
		for (int i = 0; i < N; i++)
			if (is_bcast(mbus_cmd_i[i]))
				held = 1'b1;
		return !held && accepted == served && svc_phase == PH_IDLE;
	endfunction

	task automatic run_traffic(input string name, input bit slow, input int cycles);
		int err_before;
		int acc_before;
		int n;
		err_before = errors;
		acc_before = accepted;
		slow_snoop = slow;
		max_open = 0;
		gen_en = 1'b1;
		repeat (cycles) @(posedge clk);
		gen_en = 1'b0;
		n = 0;
		while (!drained() && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!drained()) begin
			timed_out = 1'b1;
			$display("Timeout: %s traffic did not drain within %0d cycles", name, TIMEOUT);
		end
		if (slow)
			assert (max_open > DEPTH) else report_fail("FIFO never filled under back-pressure");
		$display("Test %s: %0d broadcasts, at most %0d open, %0d errors",
			name, accepted - acc_before, max_open, errors - err_before);
	endtask

	initial begin
		rng = 32'd62311;
		rst = 1'b1;
		hold_idle = 1'b1;
		gen_en = 1'b0;
		slow_snoop = 1'b0;
		for (int i = 0; i < N; i++) begin
			mbus_cmd_i[i] = mesi_bus_pkg::MBUS_NOP;
			ack_wait[i] = -1;
		end
		mbus_addr_i = '0;
		cbus_ack_i = '0;
		prev_ack = '0;
		svc_phase = PH_IDLE;
		svc_src = 0;
		svc_write = 1'b0;
		svc_addr = '0;
		svc_pend = '0;
		accepted = 0;
		served = 0;
		max_open = 0;
		errors = 0;
		timed_out = 1'b0;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (3) @(posedge clk); // Still quiet just after reset
		hold_idle = 1'b0;
		$display("Test reset: %0d errors", errors);

		run_traffic("random", 1'b0, 400);
		if (!timed_out)
			run_traffic("backpressure", 1'b1, 300);

		$display("Summary: %0d accepted, %0d served, %0d errors", accepted, served, errors);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: rtl/mesi_isc.sv
`include "mesi_isc_defs.svh"

module mesi_isc (
	input  logic clk,
	input  logic rst,
	// Main buses
	input  mesi_bus_pkg::mbus_cmd_e [`MESI_NUM_MASTERS-1:0] mbus_cmd_i,
	input  mesi_bus_pkg::addr_t [`MESI_NUM_MASTERS-1:0] mbus_addr_i,
	output logic [`MESI_NUM_MASTERS-1:0] mbus_ack_o,
	// Coherence buses
	input  logic [`MESI_NUM_MASTERS-1:0] cbus_ack_i,
	output mesi_bus_pkg::addr_t cbus_addr_o, // Shared by all masters
	output mesi_bus_pkg::cbus_cmd_e [`MESI_NUM_MASTERS-1:0] cbus_cmd_o
);

	mesi_isc_bcast_if push_bus (); // Arbiter into FIFO
	mesi_isc_bcast_if head_bus (); // FIFO head into snoop controller

	mesi_isc_breq_arb breq_arb_inst (
		.clk        (clk),
		.rst        (rst),
		.mbus_cmd_i (mbus_cmd_i),
		.mbus_addr_i(mbus_addr_i),
		.mbus_ack_o (mbus_ack_o),
		.push_bus   (push_bus.sender)
	);

	mesi_isc_bcast_fifo #(
		.DEPTH(`MESI_BCAST_FIFO_DEPTH)
	) bcast_fifo_inst (
		.clk     (clk),
		.rst     (rst),
		.push_bus(push_bus.receiver),
		.head_bus(head_bus.sender)
	);

	mesi_isc_snoop_ctrl snoop_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.head_bus   (head_bus.receiver),
		.cbus_ack_i (cbus_ack_i),
		.cbus_addr_o(cbus_addr_o),
		.cbus_cmd_o (cbus_cmd_o)
	);

endmodule

// File: rtl/mesi_isc_snoop_ctrl.sv
`include "mesi_isc_defs.svh"

module mesi_isc_snoop_ctrl (
	input  logic clk,
	input  logic rst,
	mesi_isc_bcast_if.receiver head_bus,
	input  logic [`MESI_NUM_MASTERS-1:0] cbus_ack_i,
	output mesi_bus_pkg::addr_t cbus_addr_o,
	output mesi_bus_pkg::cbus_cmd_e [`MESI_NUM_MASTERS-1:0] cbus_cmd_o
);

	localparam int N = `MESI_NUM_MASTERS;
	localparam logic [N-1:0] ONE_HOT0 = N'(1);

	mesi_isc_pkg::snoop_state_e state;
	mesi_isc_pkg::bcast_kind_e kind_q; // Captured entry
	mesi_bus_pkg::master_id_t src_q;
	logic [N-1:0] pend; // Snoopers not yet acked
	logic [N-1:0] pend_left;
	mesi_bus_pkg::cbus_cmd_e snoop_cmd;
	mesi_bus_pkg::cbus_cmd_e enable_cmd;

	// Busy for the whole service
	assign head_bus.full = (state != mesi_isc_pkg::ST_IDLE);

	assign pend_left = pend & ~cbus_ack_i;

	always_comb begin
		if (kind_q == mesi_isc_pkg::BCAST_READ) begin
			snoop_cmd = mesi_bus_pkg::CBUS_RD_SNOOP;
			enable_cmd = mesi_bus_pkg::CBUS_EN_RD;
		end else begin
			snoop_cmd = mesi_bus_pkg::CBUS_WR_SNOOP;
			enable_cmd = mesi_bus_pkg::CBUS_EN_WR;
		end
	end

	// ***********************************************************************
	// Service FSM
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mesi_isc_pkg::ST_IDLE;
			pend <= '0;
			cbus_addr_o <= '0;
		end else begin
			case (state)
				mesi_isc_pkg::ST_IDLE: begin
					if (head_bus.push) begin // Head popped at this edge
						cbus_addr_o <= head_bus.addr;
						pend <= ~(ONE_HOT0 << head_bus.src); // All but the requester
						state <= mesi_isc_pkg::ST_SNOOP;
					end
				end
				mesi_isc_pkg::ST_SNOOP: begin
					pend <= pend_left;
					if (pend_left == '0)
						state <= mesi_isc_pkg::ST_ENABLE;
				end
				mesi_isc_pkg::ST_ENABLE: begin
					if (cbus_ack_i[src_q])
						state <= mesi_isc_pkg::ST_IDLE;
				end
				default: state <= mesi_isc_pkg::ST_IDLE;
			endcase
		end
	end

	// Entry fields, only looked at outside idle
	always_ff @(posedge clk) begin
		if (state == mesi_isc_pkg::ST_IDLE && head_bus.push) begin
			kind_q <= mesi_isc_pkg::bcast_kind_e'(head_bus.kind);
			src_q <= head_bus.src;
		end
	end

	// ***********************************************************************
	// Per-master coherence commands
	// ***********************************************************************

	always_comb begin
		for (int i = 0; i < N; i++) begin
			cbus_cmd_o[i] = mesi_bus_pkg::CBUS_NOP;
			if (state == mesi_isc_pkg::ST_SNOOP && pend[i])
				cbus_cmd_o[i] = snoop_cmd; // Drops once this snooper acks
			else if (state == mesi_isc_pkg::ST_ENABLE && int'(src_q) == i)
				cbus_cmd_o[i] = enable_cmd;
		end
	end

endmodule

// File: rtl/mesi_isc_bcast_fifo.sv
`include "mesi_isc_defs.svh"

module mesi_isc_bcast_fifo #(
	parameter int DEPTH = `MESI_BCAST_FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	mesi_isc_bcast_if.receiver push_bus,
	mesi_isc_bcast_if.sender head_bus
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	// Kind bit, master index, address
	localparam int ENTRY_W = 1 + $clog2(`MESI_NUM_MASTERS) + `MESI_ADDR_WIDTH;

	logic [ENTRY_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign push_bus.full = (count == CNT_W'(DEPTH));
	assign do_push = push_bus.push && !push_bus.full;

	// Oldest entry, valid whenever something is stored
	assign head_bus.push = (count != '0);
	assign {head_bus.kind, head_bus.src, head_bus.addr} = mem[rd_ptr];
	assign do_pop = head_bus.push && !head_bus.full; // Consumer not busy

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= {push_bus.kind, push_bus.src, push_bus.addr};
	end

	// ***********************************************************************
	// Pointers and occupancy
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: rtl/mesi_isc_breq_arb.sv
`include "mesi_isc_defs.svh"

module mesi_isc_breq_arb (
	input  logic clk,
	input  logic rst,
	input  mesi_bus_pkg::mbus_cmd_e [`MESI_NUM_MASTERS-1:0] mbus_cmd_i,
	input  mesi_bus_pkg::addr_t [`MESI_NUM_MASTERS-1:0] mbus_addr_i,
	output logic [`MESI_NUM_MASTERS-1:0] mbus_ack_o,
	mesi_isc_bcast_if.sender push_bus
);

	localparam int N = `MESI_NUM_MASTERS;

	logic [N-1:0] cand; // Broadcast shown and not being acked
	logic found;
	mesi_bus_pkg::master_id_t sel;
	mesi_bus_pkg::master_id_t rr_ptr; // Highest priority master

	// ***********************************************************************
	// Candidate search
	// ***********************************************************************

	always_comb begin
		for (int i = 0; i < N; i++) begin
			cand[i] = (mbus_cmd_i[i] == mesi_bus_pkg::MBUS_RD_BCAST ||
				mbus_cmd_i[i] == mesi_bus_pkg::MBUS_WR_BCAST) && !mbus_ack_o[i];
		end
	end

	// First candidate at or after the pointer
	always_comb begin
		int idx;
		found = 1'b0;
		sel = '0;
		for (int off = 0; off < N; off++) begin
			idx = (int'(rr_ptr) + off) % N;
			if (!found && cand[idx]) begin
				found = 1'b1;
				sel = mesi_bus_pkg::master_id_t'(idx);
			end
		end
	end

	// ***********************************************************************
	// Push toward the FIFO
	// ***********************************************************************

	assign push_bus.push = found;
	assign push_bus.src = sel;
	assign push_bus.addr = mbus_addr_i[sel];

	always_comb begin
		if (mbus_cmd_i[sel] == mesi_bus_pkg::MBUS_RD_BCAST)
			push_bus.kind = mesi_isc_pkg::BCAST_READ;
		else
			push_bus.kind = mesi_isc_pkg::BCAST_WRITE;
	end

	// Ack pulse for the accepted master, pointer moves past it
	always_ff @(posedge clk) begin
		if (rst) begin
			mbus_ack_o <= '0;
			rr_ptr <= '0;
		end else begin
			mbus_ack_o <= '0; // One cycle only
			if (found && !push_bus.full) begin
				mbus_ack_o[sel] <= 1'b1;
				rr_ptr <= mesi_bus_pkg::master_id_t'((int'(sel) + 1) % N);
			end
		end
	end

endmodule

// File: rtl/mesi_isc_bcast_if.sv
interface mesi_isc_bcast_if;

	// Entry moves at a clock edge with push high and full low
	logic push; // Entry valid this cycle
	logic [$bits(mesi_isc_pkg::bcast_kind_e)-1:0] kind;
	mesi_bus_pkg::master_id_t src; // Requesting master
	mesi_bus_pkg::addr_t addr;
	logic full; // Receiver cannot take an entry

	modport sender (
		output push,
		output kind,
		output src,
		output addr,
		input  full
	);

	modport receiver (
		input  push,
		input  kind,
		input  src,
		input  addr,
		output full
	);

endinterface

// File: rtl/mesi_isc_pkg.sv
`include "mesi_isc_defs.svh"

package mesi_isc_pkg;

	// Kind of an accepted broadcast, kept with the entry
	typedef enum logic {
		BCAST_READ  = 1'b0,
		BCAST_WRITE = 1'b1
	} bcast_kind_e;

	// ***********************************************************************
	// Snoop controller
	// ***********************************************************************

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0, // Waiting for a FIFO head
		ST_SNOOP  = 2'd1, // Snoops out, collecting acks
		ST_ENABLE = 2'd2  // Enable held toward the requester
	} snoop_state_e;

endpackage

// File: rtl/mesi_bus_pkg.sv
`include "mesi_isc_defs.svh"

package mesi_bus_pkg;

	// Commands a master places on its main bus
	typedef enum logic [`MESI_MBUS_CMD_WIDTH-1:0] {
		MBUS_NOP      = 3'd0,
		MBUS_WRITE    = 3'd1, // Plain write, not handled here
		MBUS_READ     = 3'd2, // Plain read, not handled here
		MBUS_WR_BCAST = 3'd3,
		MBUS_RD_BCAST = 3'd4
	} mbus_cmd_e;

	// Commands the controller sends on each coherence bus
	typedef enum logic [`MESI_CBUS_CMD_WIDTH-1:0] {
		CBUS_NOP      = 3'd0,
		CBUS_WR_SNOOP = 3'd1,
		CBUS_RD_SNOOP = 3'd2,
		CBUS_EN_WR    = 3'd3, // Requester may go on with its write
		CBUS_EN_RD    = 3'd4  // Requester may go on with its read
	} cbus_cmd_e;

	// Master index
	typedef logic [$clog2(`MESI_NUM_MASTERS)-1:0] master_id_t;

	typedef logic [`MESI_ADDR_WIDTH-1:0] addr_t;

endpackage

// File: include/mesi_isc_defs.svh
`ifndef MESI_ISC_DEFS_SVH
`define MESI_ISC_DEFS_SVH

// ***************************************************************************
// System sizes
// ***************************************************************************

`define MESI_ADDR_WIDTH 32     // Main and coherence bus address
`define MESI_NUM_MASTERS 4     // Cores on the snoop network

// ***************************************************************************
// Bus command widths and queueing
// ***************************************************************************

`define MESI_MBUS_CMD_WIDTH 3
`define MESI_CBUS_CMD_WIDTH 3

// Default number of accepted broadcasts waiting for service
`define MESI_BCAST_FIFO_DEPTH 4

`endif
